// ==== source/psram_ctrl_config.svh ====
// Timing counts, burst sizes and widths for the PSRAM controller
// Include in any file that sizes logic from these values

`ifndef PSRAM_CTRL_CONFIG_SVH
`define PSRAM_CTRL_CONFIG_SVH

// Power-up wait, 150 us at 48 MHz
`define PSRAM_STARTUP_CYCLES 7200
// Wait after the reset command, 400 ns
`define PSRAM_RESET_CYCLES 20

// Pad phases carried per clk cycle
`define PSRAM_PHASES 4

// AXI byte address, 32 Mbyte device
`define PSRAM_ADDR_W 25
// Step counter, longest table is read-ID at 20 steps
`define PSRAM_STEP_W 5

// Burst shapes
`define PSRAM_RD_WORDS 4
`define PSRAM_WR_WORDS 8

`endif

// ==== source/psram_spi_pkg.sv ====
// Pad-side types: one clk cycle of PSRAM pad activity as four phase slots
// Slot 0 is the first phase sent by the pad serializer
`default_nettype none

`include "psram_ctrl_config.svh"

package psram_spi_pkg;

	typedef logic [7:0] spi_byte_t;

	// One bit per phase, phase 0 in the MSB
	typedef logic [0:`PSRAM_PHASES-1] spi_phase_t;

	typedef struct packed {
		spi_phase_t clk;
		// Active high here, pad inverts it
		spi_phase_t cs;
		spi_phase_t data_oe;
		spi_byte_t [0:`PSRAM_PHASES-1] data;
		// Bit 0 holds first byte, bit 1 closes the word
		logic [0:`PSRAM_PHASES-1][1:0] le;
		spi_phase_t rwds;
		spi_phase_t rwds_oe;
	} spi_out_t;

	typedef struct packed {
		spi_byte_t [0:`PSRAM_PHASES-1] data;
		spi_phase_t rwds;
		// Latch enables, returned with the pad delay
		logic [0:`PSRAM_PHASES-1][1:0] le;
	} spi_in_t;

endpackage

`default_nettype wire

// ==== source/psram_cmd_pkg.sv ====
// Control-side types: command codes, sequencer states and AXI words
// Shared by the sequencer, the wave table and the read latch
`default_nettype none

`include "psram_ctrl_config.svh"

package psram_cmd_pkg;

	typedef enum logic [2:0] {
		CMD_RESET,
		CMD_READ_ID,
		CMD_WRITE_LATENCY,
		CMD_READ_MEM,
		CMD_WRITE_MEM
	} psram_cmd_t;

	// Each command has a launch state and a wait-for-last state
	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_STARTUP,
		SEQ_CMD_RESET, SEQ_CMD_RESET_WAIT,
		SEQ_CMD_RESET_DELAY, SEQ_CMD_RESET_DELAY_WAIT,
		SEQ_READY,
		SEQ_CMD_RDID7, SEQ_CMD_RDID7_WAIT,
		SEQ_CMD_WRLAT, SEQ_CMD_WRLAT_WAIT,
		SEQ_CMD_RDMEM, SEQ_CMD_RDMEM_WAIT,
		SEQ_CMD_WRMEM, SEQ_CMD_WRMEM_WAIT
	} seq_state_t;

	typedef logic [`PSRAM_STEP_W-1:0] step_t;
	typedef logic [`PSRAM_ADDR_W-1:0] axi_addr_t;
	typedef logic [15:0] wr_word_t;

	// Half a read word, rwds beside its byte
	typedef struct packed {
		logic rwds;
		psram_spi_pkg::spi_byte_t data;
	} rd_half_t;

	typedef struct packed {
		rd_half_t first;
		rd_half_t second;
	} rd_word_t;

endpackage

`default_nettype wire

// ==== source/psram_wave_table.sv ====
// Per-command pad waveforms indexed by step, registered onto the pads
// Address and write data are spliced into the address and data steps
`timescale 1ns/100ps
`default_nettype none

`include "psram_ctrl_config.svh"

module psram_wave_table (
	input wire logic clk,
	input wire logic reset,
	input wire logic cmd_valid,
	input wire psram_cmd_pkg::psram_cmd_t cmd,
	input wire psram_cmd_pkg::step_t step,
	input wire psram_cmd_pkg::axi_addr_t rd_addr,
	input wire psram_cmd_pkg::axi_addr_t wr_addr,
	input wire psram_cmd_pkg::wr_word_t wdata,
	output psram_spi_pkg::spi_out_t spi_out,
	output logic last,
	output logic wready
);
	import psram_spi_pkg::*;
	import psram_cmd_pkg::*;

	// Step layout
	localparam int LAT_STEP = 3;
	localparam int ID_END_STEP = 19;
	localparam int DATA_STEP = 9;
	localparam int RD_END_STEP = DATA_STEP + `PSRAM_RD_WORDS;
	localparam int WR_END_STEP = DATA_STEP + `PSRAM_WR_WORDS - 1;
	localparam int ADDR_PAD_W = 32 - `PSRAM_ADDR_W;

	logic [31:0] rd_bytes;
	logic [31:0] wr_bytes;
	spi_out_t row;
	logic row_last;
	logic row_rdy;

	// Reads align to 8 bytes, writes to 16, sent MSB first
	assign rd_bytes = {{ADDR_PAD_W{1'b0}}, rd_addr[`PSRAM_ADDR_W-1:3], 3'b000};
	assign wr_bytes = {{ADDR_PAD_W{1'b0}}, wr_addr[`PSRAM_ADDR_W-1:4], 4'b0000};

	// Byte b0 on rising edge (phases 0-1), b1 on falling edge (phases 2-3)
	function automatic spi_out_t pad_bytes(input spi_byte_t b0, input spi_byte_t b1);
		spi_out_t p;
		p = '0;
		p.clk = 4'b0110;
		p.cs = 4'b1111;
		p.data_oe = 4'b1111;
		p.data = {b0, b0, b1, b1};
		return p;
	endfunction

	// Clock running, bus released to the device
	function automatic spi_out_t pad_clock();
		spi_out_t p;
		p = '0;
		p.clk = 4'b0110;
		p.cs = 4'b1111;
		return p;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Table lookup
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int s;
		s = int'(step);
		row = '0;
		row_last = 1'b0;
		row_rdy = 1'b0;
		if (cmd_valid) begin
			case (cmd)
				// Reset enable, gap, reset
				CMD_RESET: begin
					case (s) inside
						0: row = pad_bytes(8'h66, 8'h66);
						2: begin
							row = pad_bytes(8'h99, 8'h99);
							row_last = 1'b1;
						end
						default: row = '0;
					endcase
				end
				// Latency 7 before config, ID bytes clocked but never latched
				CMD_READ_ID: begin
					case (s) inside
						0: row = pad_bytes(8'h9F, 8'h9F);
						[1:2]: row = pad_bytes(8'h00, 8'h00);
						[LAT_STEP:ID_END_STEP-1]: row = pad_clock();
						ID_END_STEP: row_last = 1'b1;
						default: row = '0;
					endcase
				end
				// Write enable, then CR0 = 8FEF for latency 3
				CMD_WRITE_LATENCY: begin
					case (s) inside
						0: row = pad_bytes(8'h06, 8'h06);
						2: row = pad_bytes(8'h71, 8'h71);
						[3:4]: row = pad_bytes(8'h00, 8'h00);
						5: begin
							row = pad_bytes(8'h8F, 8'hEF);
							row_last = 1'b1;
						end
						default: row = '0;
					endcase
				end
				CMD_READ_MEM: begin
					case (s) inside
						0: row = pad_bytes(8'hEE, 8'hEE);
						1: row = pad_bytes(rd_bytes[31:24], rd_bytes[23:16]);
						2: row = pad_bytes(rd_bytes[15:8], rd_bytes[7:0]);
						[LAT_STEP:DATA_STEP-1]: row = pad_clock();
						// Hold byte at phase 2, close the word at the next phase 0
						[DATA_STEP:RD_END_STEP-1]: begin
							row = pad_clock();
							row.le[2] = 2'b01;
							if (s != DATA_STEP)
								row.le[0] = 2'b10;
						end
						RD_END_STEP: begin
							row.le[0] = 2'b10;
							row_last = 1'b1;
						end
						default: row = '0;
					endcase
				end
				CMD_WRITE_MEM: begin
					case (s) inside
						0: row = pad_bytes(8'hDE, 8'hDE);
						1: row = pad_bytes(wr_bytes[31:24], wr_bytes[23:16]);
						2: row = pad_bytes(wr_bytes[15:8], wr_bytes[7:0]);
						[LAT_STEP:DATA_STEP-2]: row = pad_clock();
						// Ready leads the data step by one, matching the output register
						DATA_STEP-1: begin
							row = pad_clock();
							row_rdy = 1'b1;
						end
						[DATA_STEP:WR_END_STEP]: begin
							row = pad_bytes(wdata[15:8], wdata[7:0]);
							row.rwds_oe = 4'b1111;
							row_rdy = (s != WR_END_STEP);
							row_last = (s == WR_END_STEP);
						end
						default: row = '0;
					endcase
				end
				default: row = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			spi_out <= '0;
			last <= 1'b0;
			wready <= 1'b0;
		end else begin
			spi_out <= row;
			last <= row_last;
			wready <= row_rdy;
		end
	end

endmodule

`default_nettype wire

// ==== source/psram_sequencer.sv ====
// Power-up sequence and read/write dispatch for the PSRAM controller
// Presents command and step to the wave table and waits for its last flag
`timescale 1ns/100ps
`default_nettype none

`include "psram_ctrl_config.svh"

module psram_sequencer (
	input wire logic clk,
	input wire logic reset,
	input wire logic arvalid,
	input wire logic awvalid,
	input wire psram_cmd_pkg::axi_addr_t araddr,
	input wire psram_cmd_pkg::axi_addr_t awaddr,
	input wire logic last,
	output logic cmd_valid,
	output psram_cmd_pkg::psram_cmd_t cmd,
	output psram_cmd_pkg::step_t step,
	output psram_cmd_pkg::axi_addr_t rd_addr,
	output psram_cmd_pkg::axi_addr_t wr_addr,
	output logic arready,
	output logic awready,
	output logic bvalid,
	output logic psram_ready
);
	import psram_cmd_pkg::*;

	localparam int DELAY_W = $clog2(`PSRAM_STARTUP_CYCLES + 1);

	seq_state_t state;
	seq_state_t next_state;
	logic [DELAY_W-1:0] delay;
	logic cmd_start;

	always_comb begin
		next_state = state;
		case (state)
			SEQ_IDLE: next_state = SEQ_STARTUP;
			SEQ_STARTUP: next_state = (delay == '0) ? SEQ_CMD_RESET : SEQ_STARTUP;
			SEQ_CMD_RESET: next_state = SEQ_CMD_RESET_WAIT;
			SEQ_CMD_RESET_WAIT: next_state = last ? SEQ_CMD_RESET_DELAY : state;
			SEQ_CMD_RESET_DELAY: next_state = SEQ_CMD_RESET_DELAY_WAIT;
			SEQ_CMD_RESET_DELAY_WAIT: next_state = (delay == '0) ? SEQ_CMD_RDID7 : state;
			SEQ_CMD_RDID7: next_state = SEQ_CMD_RDID7_WAIT;
			SEQ_CMD_RDID7_WAIT: next_state = last ? SEQ_CMD_WRLAT : state;
			SEQ_CMD_WRLAT: next_state = SEQ_CMD_WRLAT_WAIT;
			SEQ_CMD_WRLAT_WAIT: next_state = last ? SEQ_READY : state;
			// Read wins over write
			SEQ_READY: begin
				if (arvalid)
					next_state = SEQ_CMD_RDMEM;
				else if (awvalid)
					next_state = SEQ_CMD_WRMEM;
			end
			SEQ_CMD_RDMEM: next_state = SEQ_CMD_RDMEM_WAIT;
			SEQ_CMD_RDMEM_WAIT: next_state = last ? SEQ_READY : state;
			SEQ_CMD_WRMEM: next_state = SEQ_CMD_WRMEM_WAIT;
			SEQ_CMD_WRMEM_WAIT: next_state = last ? SEQ_READY : state;
			default: next_state = SEQ_IDLE;
		endcase
	end

	// Command seen by the table, valid only in the wait states
	always_comb begin
		cmd = CMD_RESET;
		cmd_valid = 1'b0;
		cmd_start = 1'b0;
		case (state)
			SEQ_CMD_RESET, SEQ_CMD_RDID7, SEQ_CMD_WRLAT, SEQ_CMD_RDMEM, SEQ_CMD_WRMEM:
				cmd_start = 1'b1;
			SEQ_CMD_RESET_WAIT: cmd_valid = 1'b1;
			SEQ_CMD_RDID7_WAIT: begin
				cmd = CMD_READ_ID;
				cmd_valid = 1'b1;
			end
			SEQ_CMD_WRLAT_WAIT: begin
				cmd = CMD_WRITE_LATENCY;
				cmd_valid = 1'b1;
			end
			SEQ_CMD_RDMEM_WAIT: begin
				cmd = CMD_READ_MEM;
				cmd_valid = 1'b1;
			end
			SEQ_CMD_WRMEM_WAIT: begin
				cmd = CMD_WRITE_MEM;
				cmd_valid = 1'b1;
			end
			default: cmd_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			step <= '0;
			delay <= DELAY_W'(`PSRAM_STARTUP_CYCLES);
			psram_ready <= 1'b0;
		end else begin
			state <= next_state;
			// Step 0 lands on the first wait cycle
			if (cmd_start)
				step <= '0;
			else if (cmd_valid)
				step <= step + 1'b1;
			if (state == SEQ_IDLE)
				delay <= DELAY_W'(`PSRAM_STARTUP_CYCLES);
			else if (state == SEQ_CMD_RESET_DELAY)
				delay <= DELAY_W'(`PSRAM_RESET_CYCLES);
			else if (delay != '0)
				delay <= delay - 1'b1;
			// Sticky once config write completes
			if (state == SEQ_CMD_WRLAT_WAIT && last)
				psram_ready <= 1'b1;
		end
	end

	// Address capture on acceptance
	always_ff @(posedge clk) begin
		if (arready)
			rd_addr <= araddr;
		if (awready)
			wr_addr <= awaddr;
	end

	assign arready = (state == SEQ_READY) && arvalid;
	assign awready = (state == SEQ_READY) && !arvalid && awvalid;
	assign bvalid = (state == SEQ_CMD_WRMEM_WAIT) && last;

endmodule

`default_nettype wire

// ==== source/psram_read_latch.sv ====
// Builds 18-bit read words from returned pad bytes and latch enables
// Word and valid pulse appear one clk after the closing latch enable
`timescale 1ns/100ps
`default_nettype none

`include "psram_ctrl_config.svh"

module psram_read_latch (
	input wire logic clk,
	input wire logic reset,
	input wire psram_spi_pkg::spi_in_t spi_in,
	output psram_cmd_pkg::rd_word_t rdata,
	output logic rvalid
);
	import psram_cmd_pkg::*;

	rd_half_t held;
	rd_half_t held_next;
	rd_word_t word;
	logic word_found;

	// Walk phases in order, first byte may come from the previous cycle
	always_comb begin
		rd_half_t cur;
		held_next = held;
		word = '0;
		word_found = 1'b0;
		for (int p = 0; p < `PSRAM_PHASES; p++) begin
			cur.rwds = spi_in.rwds[p];
			cur.data = spi_in.data[p];
			if (spi_in.le[p][1]) begin
				word.first = held_next;
				word.second = cur;
				word_found = 1'b1;
			end
			if (spi_in.le[p][0])
				held_next = cur;
		end
	end

	always_ff @(posedge clk) begin
		held <= held_next;
		if (word_found)
			rdata <= word;
	end

	always_ff @(posedge clk) begin
		if (reset)
			rvalid <= 1'b0;
		else
			rvalid <= word_found;
	end

endmodule

`default_nettype wire

// ==== source/psram_ctrl.sv ====
// PSRAM controller top, 8-bit pad bus on one side and simplified AXI4 on the other
// Pads carry 4-phase vectors per clk, serialized outside this block
`timescale 1ns/100ps
`default_nettype none

module psram_ctrl (
	input wire logic clk,
	input wire logic reset,
	// Pad side
	output psram_spi_pkg::spi_out_t spi_out,
	input wire psram_spi_pkg::spi_in_t spi_in,
	output logic psram_ready,
	// Write data, address and response
	input wire psram_cmd_pkg::wr_word_t wdata,
	output logic wready,
	input wire psram_cmd_pkg::axi_addr_t awaddr,
	input wire logic awvalid,
	output logic awready,
	output logic bvalid,
	output logic [1:0] bresp,
	// Read address and data
	input wire psram_cmd_pkg::axi_addr_t araddr,
	input wire logic arvalid,
	output logic arready,
	output psram_cmd_pkg::rd_word_t rdata,
	output logic rvalid
);
	import psram_cmd_pkg::*;

	logic cmd_valid;
	psram_cmd_t cmd;
	step_t step;
	axi_addr_t rd_addr;
	axi_addr_t wr_addr;
	logic last;

	psram_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.arvalid(arvalid),
		.awvalid(awvalid),
		.araddr(araddr),
		.awaddr(awaddr),
		.last(last),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.step(step),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.arready(arready),
		.awready(awready),
		.bvalid(bvalid),
		.psram_ready(psram_ready)
	);

	psram_wave_table u_wave_table (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.step(step),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.wdata(wdata),
		.spi_out(spi_out),
		.last(last),
		.wready(wready)
	);

	psram_read_latch u_read_latch (
		.clk(clk),
		.reset(reset),
		.spi_in(spi_in),
		.rdata(rdata),
		.rvalid(rvalid)
	);

	// Writes always complete OKAY
	assign bresp = 2'b00;

endmodule

`default_nettype wire

// ==== testbench/psram_device_model.sv ====
// Behavioral PSRAM on the 4-phase pad vectors, decodes command, address and write data
// Returns read bytes on the phases that carry a latch enable, echoing the enables back
`timescale 1ns/100ps
`default_nettype none

`include "psram_ctrl_config.svh"

module psram_device_model (
	input wire logic clk,
	input wire logic reset,
	input wire psram_spi_pkg::spi_out_t spi_out,
	output psram_spi_pkg::spi_in_t spi_in,
	output logic cmd_strobe,
	output psram_spi_pkg::spi_byte_t cmd_byte,
	output logic [15:0] cfg_word
);
	import psram_spi_pkg::*;

	// Sparse byte memory
	spi_byte_t mem [int];
	spi_byte_t cmd;
	int oe_step;
	logic [15:0] addr_hi;
	int frame_addr;
	int rd_base;
	int rd_idx;

	// Unwritten bytes follow a pattern of the whole address
	function automatic spi_byte_t mem_byte(input int a);
		if (mem.exists(a))
			return mem[a];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Read return, one byte per phase that has a latch enable
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int idx;
		idx = rd_idx;
		spi_in = '0;
		spi_in.le = spi_out.le;
		for (int p = 0; p < `PSRAM_PHASES; p++) begin
			if (spi_out.le[p] != 2'b00) begin
				spi_in.data[p] = mem_byte(rd_base + idx);
				idx++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame decode, bytes sampled at phases 0 and 2
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		int cnt;
		spi_byte_t d0;
		spi_byte_t d2;
		cnt = 0;
		d0 = spi_out.data[0];
		d2 = spi_out.data[2];
		for (int p = 0; p < `PSRAM_PHASES; p++)
			if (spi_out.le[p] != 2'b00)
				cnt++;
		rd_idx <= rd_idx + cnt;
		cmd_strobe <= 1'b0;
		if (reset) begin
			oe_step <= 0;
			cmd <= '0;
			cmd_byte <= '0;
			cfg_word <= '0;
			rd_idx <= 0;
			rd_base <= 0;
			frame_addr <= 0;
		end else if (!spi_out.cs[0]) begin
			// Deselect ends the frame
			oe_step <= 0;
		end else if (spi_out.data_oe[0]) begin
			oe_step <= oe_step + 1;
			case (oe_step)
				0: begin
					cmd <= d0;
					cmd_byte <= d0;
					cmd_strobe <= 1'b1;
				end
				1: addr_hi <= {d0, d2};
				2: begin
					frame_addr <= int'({addr_hi, d0, d2});
					if (cmd == 8'hEE) begin
						rd_base <= int'({addr_hi, d0, d2});
						rd_idx <= 0;
					end
				end
				default: begin
					if (cmd == 8'hDE) begin
						mem[frame_addr + 2 * (oe_step - 3)] = d0;
						mem[frame_addr + 2 * (oe_step - 3) + 1] = d2;
					end
					// Config register value after 0x71 and its address
					if (cmd == 8'h71)
						cfg_word <= {d0, d2};
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== testbench/psram_ctrl_tb.sv ====
// Testbench for the PSRAM controller, random AXI bursts against a byte reference model
// Runs power-up, write/read bursts and a read-over-write priority case
`timescale 1ns/100ps
`default_nettype none

`include "psram_ctrl_config.svh"

module psram_ctrl_tb;
	import psram_spi_pkg::*;
	import psram_cmd_pkg::*;

	localparam int READY_TIMEOUT = 20000;
	localparam int OP_TIMEOUT = 200;
	localparam int ROUNDS = 6;

	logic clk;
	logic reset;
	spi_out_t spi_out;
	spi_in_t spi_in;
	logic psram_ready;
	wr_word_t wdata;
	logic wready;
	axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	logic bvalid;
	logic [1:0] bresp;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	rd_word_t rdata;
	logic rvalid;
	logic cmd_strobe;
	spi_byte_t cmd_byte;
	logic [15:0] cfg_word;

	logic [31:0] lcg_state;
	spi_byte_t ref_mem [int];
	spi_byte_t cmd_q [$];
	wr_word_t burst_words [0:`PSRAM_WR_WORDS-1];
	int value_errors;
	int other_errors;
	bit timed_out;
	bit ready_seen;
	int rvalid_count;
	int wready_count;
	int bvalid_count;
	int reads_done;
	int writes_done;

	psram_ctrl UUT (
		.clk(clk),
		.reset(reset),
		.spi_out(spi_out),
		.spi_in(spi_in),
		.psram_ready(psram_ready),
		.wdata(wdata),
		.wready(wready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.bvalid(bvalid),
		.bresp(bresp),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid)
	);

	psram_device_model u_device (
		.clk(clk),
		.reset(reset),
		.spi_out(spi_out),
		.spi_in(spi_in),
		.cmd_strobe(cmd_strobe),
		.cmd_byte(cmd_byte),
		.cfg_word(cfg_word)
	);

	// 100 ns period
	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic axi_addr_t rand_addr();
		logic [31:0] r;
		r = lcg_next();
		return r[31:7];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_cmd(input spi_byte_t exp, input spi_byte_t got);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t: pad byte expected %02h got %02h", $time, exp, got);
		end
	endtask

	task automatic check_rd_word(input rd_word_t exp, input rd_word_t got);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t: read word expected %05h got %05h", $time, exp, got);
		end
	endtask

	task automatic check_resp(input logic [1:0] exp, input logic [1:0] got);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t: bresp expected %0d got %0d", $time, exp, got);
		end
	endtask

	task automatic report_problem(input string msg);
		other_errors++;
		$display("Problem at %0t: %s", $time, msg);
	endtask

	task automatic note_timeout(input string what);
		timed_out = 1;
		other_errors++;
		$display("Timeout at %0t while waiting for %s", $time, what);
	endtask

	// Next command byte captured by the device model
	task automatic expect_next_cmd(input spi_byte_t exp);
		if (cmd_q.size() == 0)
			report_problem("no command byte seen at the pads");
		else
			check_cmd(exp, cmd_q.pop_front());
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitor, counts pulses and watches ready and requests
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!reset) begin
			if (rvalid)
				rvalid_count++;
			if (wready)
				wready_count++;
			if (bvalid) begin
				bvalid_count++;
				check_resp(2'b00, bresp);
			end
			if ((arready || awready) && !psram_ready)
				report_problem("request accepted before psram_ready");
			if (psram_ready)
				ready_seen = 1;
			else if (ready_seen)
				report_problem("psram_ready dropped after rising");
			if (cmd_strobe)
				cmd_q.push_back(cmd_byte);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sequences
	//////////////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		if (spi_out !== '0)
			report_problem("pad outputs not zero after reset");
		if ({psram_ready, arready, awready, wready, bvalid, rvalid} !== 6'd0)
			report_problem("control outputs not zero after reset");
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		// Requests held through the startup wait must be refused
		arvalid <= 1'b1;
		awvalid <= 1'b1;
		while (!psram_ready && !timed_out) begin
			@(posedge clk);
			n++;
			if (n == `PSRAM_STARTUP_CYCLES) begin
				arvalid <= 1'b0;
				awvalid <= 1'b0;
			end
			if (n > READY_TIMEOUT)
				note_timeout("psram_ready");
		end
		arvalid <= 1'b0;
		awvalid <= 1'b0;
		if (!timed_out && n < `PSRAM_STARTUP_CYCLES)
			report_problem("psram_ready rose before the startup wait ended");
	endtask

	task automatic check_power_up();
		spi_byte_t exp [0:4];
		exp = '{8'h66, 8'h99, 8'h9F, 8'h06, 8'h71};
		if (cmd_q.size() != 5)
			report_problem("wrong number of power-up commands");
		for (int i = 0; i < 5; i++)
			expect_next_cmd(exp[i]);
		// Config register data bytes
		check_cmd(8'h8F, cfg_word[15:8]);
		check_cmd(8'hEF, cfg_word[7:0]);
		cmd_q.delete();
	endtask

	task automatic make_words();
		logic [31:0] r;
		for (int k = 0; k < `PSRAM_WR_WORDS; k++) begin
			r = lcg_next();
			burst_words[k] = r[23:8];
		end
	endtask

	// Waits for acceptance, feeds words on wready, ends on bvalid
	task automatic finish_write(input axi_addr_t addr);
		int n;
		int idx;
		int base;
		bit got_b;
		if (timed_out)
			return;
		n = 0;
		while (!awready) begin
			@(posedge clk);
			n++;
			if (n > OP_TIMEOUT) begin
				note_timeout("awready");
				return;
			end
		end
		awvalid <= 1'b0;
		idx = 0;
		n = 0;
		got_b = 0;
		while (!got_b) begin
			@(posedge clk);
			n++;
			if (wready) begin
				idx++;
				if (idx < `PSRAM_WR_WORDS)
					wdata <= burst_words[idx];
			end
			if (bvalid)
				got_b = 1;
			else if (n > OP_TIMEOUT) begin
				note_timeout("bvalid");
				return;
			end
		end
		if (idx != `PSRAM_WR_WORDS)
			report_problem($sformatf("write burst took %0d words", idx));
		// Reference model, 16-byte aligned, high byte first
		base = int'(addr) & ~15;
		for (int k = 0; k < `PSRAM_WR_WORDS; k++) begin
			ref_mem[base + 2 * k] = burst_words[k][15:8];
			ref_mem[base + 2 * k + 1] = burst_words[k][7:0];
		end
		expect_next_cmd(8'hDE);
		writes_done++;
	endtask

	// Collects one read burst, flags awready seen before the last word
	task automatic collect_read(input axi_addr_t addr, output bit aw_early);
		int n;
		int k;
		int base;
		rd_word_t exp;
		aw_early = 0;
		if (timed_out)
			return;
		base = int'(addr) & ~7;
		n = 0;
		k = 0;
		while (k < `PSRAM_RD_WORDS) begin
			@(posedge clk);
			n++;
			if (awready && k < `PSRAM_RD_WORDS - 1)
				aw_early = 1;
			if (rvalid) begin
				exp.first.rwds = 1'b0;
				exp.first.data = ref_mem[base + 2 * k];
				exp.second.rwds = 1'b0;
				exp.second.data = ref_mem[base + 2 * k + 1];
				check_rd_word(exp, rdata);
				k++;
			end else if (n > OP_TIMEOUT) begin
				note_timeout("rvalid");
				return;
			end
		end
		expect_next_cmd(8'hEE);
		reads_done++;
	endtask

	task automatic write_burst(input axi_addr_t addr);
		if (timed_out)
			return;
		make_words();
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= burst_words[0];
		finish_write(addr);
	endtask

	task automatic read_burst(input axi_addr_t addr);
		int n;
		bit aw_early;
		if (timed_out)
			return;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		n = 0;
		while (!arready) begin
			@(posedge clk);
			n++;
			if (n > OP_TIMEOUT) begin
				note_timeout("arready");
				return;
			end
		end
		arvalid <= 1'b0;
		collect_read(addr, aw_early);
	endtask

	// Both requests in the same cycle, read goes first
	task automatic read_and_write_together(input axi_addr_t raddr, input axi_addr_t waddr);
		int n;
		bit aw_early;
		if (timed_out)
			return;
		make_words();
		@(posedge clk);
		araddr <= raddr;
		arvalid <= 1'b1;
		awaddr <= waddr;
		awvalid <= 1'b1;
		wdata <= burst_words[0];
		n = 0;
		while (!arready) begin
			@(posedge clk);
			n++;
			if (awready)
				report_problem("write accepted ahead of a pending read");
			if (n > OP_TIMEOUT) begin
				note_timeout("arready with both requests");
				return;
			end
		end
		arvalid <= 1'b0;
		collect_read(raddr, aw_early);
		if (aw_early)
			report_problem("write accepted before the read completed");
		finish_write(waddr);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main flow
	//////////////////////////////////////////////////////////////////////

	initial begin
		axi_addr_t waddr;
		axi_addr_t next_addr;
		logic [31:0] r;
		clk = 1'b0;
		reset = 1'b1;
		wdata = '0;
		awaddr = '0;
		awvalid = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		lcg_state = 32'h6887;
		value_errors = 0;
		other_errors = 0;
		timed_out = 0;
		ready_seen = 0;
		rvalid_count = 0;
		wready_count = 0;
		bvalid_count = 0;
		reads_done = 0;
		writes_done = 0;
		waddr = '0;

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_reset_state();

		wait_ready();
		if (!timed_out)
			check_power_up();

		for (int i = 0; i < ROUNDS; i++) begin
			waddr = rand_addr();
			write_burst(waddr);
			r = lcg_next();
			// Low bits below the 8-byte alignment are ignored
			read_burst({waddr[`PSRAM_ADDR_W-1:4], 4'b0000} + axi_addr_t'(r[10:8]));
			read_burst({waddr[`PSRAM_ADDR_W-1:4], 4'b1000} + axi_addr_t'(r[13:11]));
		end

		next_addr = rand_addr();
		read_and_write_together(waddr, next_addr);
		// Both halves of the 16-byte block just written
		read_burst({next_addr[`PSRAM_ADDR_W-1:4], 4'b0000});
		read_burst({next_addr[`PSRAM_ADDR_W-1:4], 4'b1000});

		repeat (4) @(posedge clk);
		if (rvalid_count != reads_done * `PSRAM_RD_WORDS)
			report_problem("rvalid pulse count does not match read bursts");
		if (wready_count != writes_done * `PSRAM_WR_WORDS)
			report_problem("wready cycle count does not match write bursts");
		if (bvalid_count != writes_done)
			report_problem("bvalid pulse count does not match write bursts");

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== psram_ctrl.f ====
+incdir+source
source/psram_spi_pkg.sv
source/psram_cmd_pkg.sv
source/psram_wave_table.sv
source/psram_sequencer.sv
source/psram_read_latch.sv
source/psram_ctrl.sv
testbench/psram_device_model.sv
testbench/psram_ctrl_tb.sv
